//--- design/mmu_pkg.sv
// MMU shared definitions
package mmu_pkg;

    // ----------------------------------------------------------
    // Default geometry
    // ----------------------------------------------------------
    localparam int PAGE_W = 10;                 // Page number bits
    localparam int OFFS_W = 10;                 // Offset within a page
    localparam int BANK_W = 2;                  // Bank select bits, four banks

    // Address and data types
    typedef logic [PAGE_W+OFFS_W-1:0] vaddr_t;  // Effective address
    typedef logic [PAGE_W+OFFS_W-1:0] paddr_t;  // Physical address
    typedef logic [PAGE_W-1:0]        page_t;   // Page number
    typedef logic [31:0]              apb_data_t;
    typedef logic [7:0]               apb_addr_t;

    // ----------------------------------------------------------
    // Register offsets
    // ----------------------------------------------------------
    localparam apb_addr_t REG_CTRL      = 8'h00; // No-paging bit, fill start/busy
    localparam apb_addr_t REG_VADDR     = 8'h04; // Effective address
    localparam apb_addr_t REG_PHYSAD    = 8'h08; // Translated address, read only
    localparam apb_addr_t REG_MAPENT    = 8'h0C; // Map entry of VADDR page
    localparam apb_addr_t REG_PHYSPG    = 8'h10; // Physical page register
    localparam apb_addr_t REG_ACCESS    = 8'h14; // Used and dirty of PHYSPG page
    localparam apb_addr_t REG_REPRIO    = 8'h18; // Reprioritize bit of PHYSPG page
    localparam apb_addr_t REG_TRANSLATE = 8'h1C; // Load PHYSPG from translation

    // APB slave sequence
    typedef enum logic [1:0] {
        IDLE,                                   // Waiting for setup
        WAIT,                                   // First access cycle
        RESP                                    // Ready high, transfer completes
    } apb_state_e;

endpackage

//--- design/mmu_apb_regs.sv
// MMU APB register block
`timescale 1ns/1ps

module mmu_apb_regs #(
    parameter int PAGE_W = mmu_pkg::PAGE_W,
    parameter int OFFS_W = mmu_pkg::OFFS_W
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  mmu_pkg::apb_addr_t i_paddr,
    input  mmu_pkg::apb_data_t i_pwdata,
    input  mmu_pkg::page_t     i_map_entry,  // Map entry of VADDR page
    input  mmu_pkg::page_t     i_xlat_page,  // Translated page
    input  mmu_pkg::paddr_t    i_physad,     // Translated address
    input  logic               i_used,
    input  logic               i_dirty,
    input  logic               i_reprio,
    input  logic               i_fill_busy,
    output mmu_pkg::apb_data_t o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,
    output logic               o_no_paging,
    output mmu_pkg::vaddr_t    o_vaddr,
    output mmu_pkg::page_t     o_vaddr_page,
    output mmu_pkg::page_t     o_physpg,
    output logic               o_wr_map,
    output logic               o_wr_access,
    output logic               o_wr_reprio,
    output logic               o_translate,
    output logic               o_fill_start,
    output mmu_pkg::apb_data_t o_wdata
);

    mmu_pkg::apb_state_e state;
    mmu_pkg::apb_data_t  rdata;                 // Read mux
    logic                known;                 // Offset maps to a register
    logic                blocked;               // Register locked by fill
    logic                err;
    logic                wr_ok;                 // Write commits at this edge

    // ----------------------------------------------------------
    // Transfer sequencing, one wait state
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mmu_pkg::IDLE;
        end else begin
            case (state)
                mmu_pkg::IDLE: begin
                    if (i_psel && !i_penable)   // Setup phase seen
                        state <= mmu_pkg::WAIT;
                end
                mmu_pkg::WAIT: state <= mmu_pkg::RESP;
                default:       state <= mmu_pkg::IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Offset decode and read data
    // ----------------------------------------------------------
    always_comb begin
        known = 1'b1;
        rdata = '0;
        case (i_paddr)
            mmu_pkg::REG_CTRL:      rdata = {30'd0, i_fill_busy, o_no_paging};
            mmu_pkg::REG_VADDR:     rdata = 32'(o_vaddr);
            mmu_pkg::REG_PHYSAD:    rdata = 32'(i_physad);
            mmu_pkg::REG_MAPENT:    rdata = 32'(i_map_entry);
            mmu_pkg::REG_PHYSPG:    rdata = 32'(o_physpg);
            mmu_pkg::REG_ACCESS:    rdata = {29'd0, i_dirty, i_used, 1'b0};
            mmu_pkg::REG_REPRIO:    rdata = {31'd0, i_reprio};
            mmu_pkg::REG_TRANSLATE: rdata = '0;  // Write-only command
            default:                known = 1'b0;
        endcase
    end

    assign blocked = i_fill_busy && (i_paddr == mmu_pkg::REG_ACCESS ||
                                     i_paddr == mmu_pkg::REG_REPRIO ||
                                     i_paddr == mmu_pkg::REG_TRANSLATE);
    assign err     = !known || blocked;

    assign o_pready  = (state == mmu_pkg::RESP);
    assign o_pslverr = o_pready && err;
    assign o_prdata  = (o_pready && !err && !i_pwrite) ? rdata : '0;

    // Command pulses in the completing cycle
    assign wr_ok        = o_pready && i_pwrite && !err;
    assign o_wr_map     = wr_ok && (i_paddr == mmu_pkg::REG_MAPENT);
    assign o_wr_access  = wr_ok && (i_paddr == mmu_pkg::REG_ACCESS);
    assign o_wr_reprio  = wr_ok && (i_paddr == mmu_pkg::REG_REPRIO);
    assign o_translate  = wr_ok && (i_paddr == mmu_pkg::REG_TRANSLATE);
    assign o_fill_start = wr_ok && (i_paddr == mmu_pkg::REG_CTRL) && i_pwdata[1];
    assign o_wdata      = i_pwdata;

    // ----------------------------------------------------------
    // Control and address registers
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_no_paging <= 1'b0;
            o_vaddr     <= '0;
            o_physpg    <= '0;
        end else if (wr_ok) begin
            case (i_paddr)
                mmu_pkg::REG_CTRL:      o_no_paging <= i_pwdata[0];
                mmu_pkg::REG_VADDR:     o_vaddr     <= i_pwdata[PAGE_W+OFFS_W-1:0];
                mmu_pkg::REG_PHYSPG:    o_physpg    <= i_pwdata[PAGE_W-1:0];
                mmu_pkg::REG_TRANSLATE: o_physpg    <= i_xlat_page; // Page of VADDR
                default: ;
            endcase
        end
    end

    assign o_vaddr_page = o_vaddr[OFFS_W +: PAGE_W]; // Virtual page number

endmodule

//--- design/page_dispatch.sv
// Page bank dispatcher and fill sequencer
`timescale 1ns/1ps

module page_dispatch #(
    parameter int PAGE_W = mmu_pkg::PAGE_W,
    parameter int BANK_W = mmu_pkg::BANK_W
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  mmu_pkg::page_t                         i_vaddr_page,
    input  mmu_pkg::page_t                         i_physpg,
    input  mmu_pkg::page_t                         i_xlat_page,
    input  logic                                   i_wr_map,
    input  logic                                   i_wr_access,
    input  logic                                   i_wr_reprio,
    input  logic                                   i_translate,
    input  logic                                   i_fill_start,
    input  mmu_pkg::apb_data_t                     i_wdata,
    output logic [2**BANK_W-1:0][PAGE_W-BANK_W-1:0] o_map_addr,
    output logic [2**BANK_W-1:0][PAGE_W-BANK_W-1:0] o_attr_addr,
    output logic [2**BANK_W-1:0]                   o_map_we,
    output logic [2**BANK_W-1:0]                   o_attr_we,   // Used bit write
    output logic [2**BANK_W-1:0]                   o_dirty_we,
    output logic [2**BANK_W-1:0]                   o_reprio_we,
    output mmu_pkg::page_t                         o_map_wdata,
    output logic                                   o_used_wdata,
    output logic                                   o_dirty_wdata,
    output logic                                   o_reprio_wdata,
    output logic                                   o_fill_busy,
    output mmu_pkg::page_t                         o_attr_page
);

    localparam int NB = 2 ** BANK_W;

    mmu_pkg::page_t    fill_cnt;                // Page being filled
    logic [BANK_W-1:0] map_bank;
    logic [BANK_W-1:0] attr_bank;

    // ----------------------------------------------------------
    // Reprioritize fill, PHYSPG up to the last page
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_fill_busy <= 1'b0;
        end else if (o_fill_busy) begin
            if (fill_cnt == mmu_pkg::page_t'(2 ** PAGE_W - 1))
                o_fill_busy <= 1'b0;            // Last page written
        end else if (i_fill_start) begin
            o_fill_busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_fill_busy)
            fill_cnt <= fill_cnt + 1'b1;        // One page per cycle
        else if (i_fill_start)
            fill_cnt <= i_physpg;
    end

    // Attribute port page, fill first
    assign o_attr_page = o_fill_busy ? fill_cnt :
                         i_translate ? i_xlat_page : i_physpg;

    assign map_bank  = i_vaddr_page[BANK_W-1:0]; // Low bits pick the bank
    assign attr_bank = o_attr_page[BANK_W-1:0];

    // ----------------------------------------------------------
    // Per-bank addresses and enables
    // ----------------------------------------------------------
    always_comb begin
        for (int b = 0; b < NB; b++) begin
            o_map_addr[b]  = i_vaddr_page[PAGE_W-1:BANK_W];
            o_attr_addr[b] = o_attr_page[PAGE_W-1:BANK_W];
            o_map_we[b]    = i_wr_map && (map_bank == BANK_W'(b));
            o_attr_we[b]   = (i_wr_access || i_translate) && (attr_bank == BANK_W'(b));
            o_dirty_we[b]  = i_wr_access && (attr_bank == BANK_W'(b)); // Kept on translate
            o_reprio_we[b] = (o_fill_busy || i_wr_reprio) && (attr_bank == BANK_W'(b));
        end
    end

    assign o_map_wdata    = i_wdata[PAGE_W-1:0];
    assign o_used_wdata   = i_translate || i_wdata[1]; // Translate marks used
    assign o_dirty_wdata  = i_wdata[2];
    assign o_reprio_wdata = o_fill_busy || i_wdata[0]; // Fill writes ones

endmodule

//--- design/page_bank.sv
// Page map and attribute bank
`timescale 1ns/1ps

module page_bank #(
    parameter int PAGE_W = mmu_pkg::PAGE_W,
    parameter int BANK_W = mmu_pkg::BANK_W
) (
    input  logic                     clk,
    input  logic [PAGE_W-BANK_W-1:0] i_map_addr,
    input  logic [PAGE_W-BANK_W-1:0] i_attr_addr,
    input  logic                     i_map_we,
    input  logic                     i_attr_we,   // Used bit write
    input  logic                     i_dirty_we,
    input  logic                     i_reprio_we,
    input  mmu_pkg::page_t           i_map_wdata,
    input  logic                     i_used_wdata,
    input  logic                     i_dirty_wdata,
    input  logic                     i_reprio_wdata,
    output mmu_pkg::page_t           o_map_entry,
    output logic                     o_used,
    output logic                     o_dirty,
    output logic                     o_reprio
);

    localparam int DEPTH = 2 ** (PAGE_W - BANK_W); // Pages held by this bank

    mmu_pkg::page_t map_mem    [DEPTH];         // Virtual to physical page
    logic           used_mem   [DEPTH];         // Page referenced
    logic           dirty_mem  [DEPTH];         // Page modified
    logic           reprio_mem [DEPTH];         // Reprioritize request

    // ----------------------------------------------------------
    // Map port
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_map_we)
            map_mem[i_map_addr] <= i_map_wdata;
        o_map_entry <= map_mem[i_map_addr];     // Registered read
    end

    // ----------------------------------------------------------
    // Attribute port
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_attr_we)
            used_mem[i_attr_addr] <= i_used_wdata;
        if (i_dirty_we)
            dirty_mem[i_attr_addr] <= i_dirty_wdata;
        if (i_reprio_we)
            reprio_mem[i_attr_addr] <= i_reprio_wdata;
        o_used   <= used_mem[i_attr_addr];
        o_dirty  <= dirty_mem[i_attr_addr];
        o_reprio <= reprio_mem[i_attr_addr];
    end

endmodule

//--- design/page_collect.sv
// Page bank collector and address assembly
`timescale 1ns/1ps

module page_collect #(
    parameter int PAGE_W = mmu_pkg::PAGE_W,
    parameter int OFFS_W = mmu_pkg::OFFS_W,
    parameter int BANK_W = mmu_pkg::BANK_W
) (
    input  logic                                clk,
    input  mmu_pkg::vaddr_t                     i_vaddr,
    input  mmu_pkg::page_t                      i_attr_page,
    input  logic                                i_no_paging,
    input  mmu_pkg::page_t [2**BANK_W-1:0]      i_bank_map,
    input  logic           [2**BANK_W-1:0]      i_bank_used,
    input  logic           [2**BANK_W-1:0]      i_bank_dirty,
    input  logic           [2**BANK_W-1:0]      i_bank_reprio,
    output mmu_pkg::page_t                      o_map_entry,
    output mmu_pkg::page_t                      o_xlat_page,
    output mmu_pkg::paddr_t                     o_physad,
    output logic                                o_used,
    output logic                                o_dirty,
    output logic                                o_reprio
);

    logic [BANK_W-1:0] map_bank_q;              // Bank of VADDR page, read aligned
    logic [BANK_W-1:0] attr_bank_q;             // Bank of attribute page
    mmu_pkg::page_t    vpage;

    always_ff @(posedge clk) begin
        map_bank_q  <= i_vaddr[OFFS_W +: BANK_W];
        attr_bank_q <= i_attr_page[BANK_W-1:0];
    end

    assign vpage       = i_vaddr[OFFS_W +: PAGE_W];
    assign o_map_entry = i_bank_map[map_bank_q];
    assign o_xlat_page = i_no_paging ? vpage : o_map_entry; // Bypass when paging off
    assign o_physad    = {o_xlat_page, i_vaddr[OFFS_W-1:0]}; // Offset passes through

    assign o_used   = i_bank_used[attr_bank_q];
    assign o_dirty  = i_bank_dirty[attr_bank_q];
    assign o_reprio = i_bank_reprio[attr_bank_q];

endmodule

//--- design/mmu_top.sv
// MMU page translation peripheral
`timescale 1ns/1ps

module mmu_top #(
    parameter int PAGE_W = mmu_pkg::PAGE_W,
    parameter int OFFS_W = mmu_pkg::OFFS_W,
    parameter int BANK_W = mmu_pkg::BANK_W
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  mmu_pkg::apb_addr_t i_paddr,
    input  mmu_pkg::apb_data_t i_pwdata,
    output mmu_pkg::apb_data_t o_prdata,
    output logic               o_pready,
    output logic               o_pslverr
);

    localparam int NB    = 2 ** BANK_W;         // Number of banks
    localparam int IDX_W = PAGE_W - BANK_W;     // Entry index within a bank

    // ----------------------------------------------------------
    // Register block links
    // ----------------------------------------------------------
    logic               no_paging;
    mmu_pkg::vaddr_t    vaddr;
    mmu_pkg::page_t     vaddr_page;
    mmu_pkg::page_t     physpg;
    logic               wr_map;
    logic               wr_access;
    logic               wr_reprio;
    logic               translate;
    logic               fill_start;
    mmu_pkg::apb_data_t wdata;
    mmu_pkg::page_t     map_entry;
    mmu_pkg::page_t     xlat_page;
    mmu_pkg::paddr_t    physad;
    logic               used;
    logic               dirty;
    logic               reprio;
    logic               fill_busy;

    // Bank array links
    logic [NB-1:0][IDX_W-1:0] map_addr;
    logic [NB-1:0][IDX_W-1:0] attr_addr;
    logic [NB-1:0]            map_we;
    logic [NB-1:0]            attr_we;
    logic [NB-1:0]            dirty_we;
    logic [NB-1:0]            reprio_we;
    mmu_pkg::page_t           map_wdata;
    logic                     used_wdata;
    logic                     dirty_wdata;
    logic                     reprio_wdata;
    mmu_pkg::page_t           attr_page;
    mmu_pkg::page_t [NB-1:0]  bank_map;
    logic [NB-1:0]            bank_used;
    logic [NB-1:0]            bank_dirty;
    logic [NB-1:0]            bank_reprio;

    mmu_apb_regs #(.PAGE_W(PAGE_W), .OFFS_W(OFFS_W)) u_mmu_apb_regs (
        .clk, .reset,
        .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
        .i_map_entry(map_entry), .i_xlat_page(xlat_page), .i_physad(physad),
        .i_used(used), .i_dirty(dirty), .i_reprio(reprio), .i_fill_busy(fill_busy),
        .o_prdata, .o_pready, .o_pslverr,
        .o_no_paging(no_paging), .o_vaddr(vaddr), .o_vaddr_page(vaddr_page),
        .o_physpg(physpg), .o_wr_map(wr_map), .o_wr_access(wr_access),
        .o_wr_reprio(wr_reprio), .o_translate(translate),
        .o_fill_start(fill_start), .o_wdata(wdata)
    );

    page_dispatch #(.PAGE_W(PAGE_W), .BANK_W(BANK_W)) u_page_dispatch (
        .clk, .reset,
        .i_vaddr_page(vaddr_page), .i_physpg(physpg), .i_xlat_page(xlat_page),
        .i_wr_map(wr_map), .i_wr_access(wr_access), .i_wr_reprio(wr_reprio),
        .i_translate(translate), .i_fill_start(fill_start), .i_wdata(wdata),
        .o_map_addr(map_addr), .o_attr_addr(attr_addr),
        .o_map_we(map_we), .o_attr_we(attr_we), .o_dirty_we(dirty_we),
        .o_reprio_we(reprio_we), .o_map_wdata(map_wdata),
        .o_used_wdata(used_wdata), .o_dirty_wdata(dirty_wdata),
        .o_reprio_wdata(reprio_wdata), .o_fill_busy(fill_busy),
        .o_attr_page(attr_page)
    );

    // One bank per group of pages
    for (genvar b = 0; b < NB; b++) begin : g_bank
        page_bank #(.PAGE_W(PAGE_W), .BANK_W(BANK_W)) u_page_bank (
            .clk,
            .i_map_addr(map_addr[b]), .i_attr_addr(attr_addr[b]),
            .i_map_we(map_we[b]), .i_attr_we(attr_we[b]),
            .i_dirty_we(dirty_we[b]), .i_reprio_we(reprio_we[b]),
            .i_map_wdata(map_wdata), .i_used_wdata(used_wdata),
            .i_dirty_wdata(dirty_wdata), .i_reprio_wdata(reprio_wdata),
            .o_map_entry(bank_map[b]), .o_used(bank_used[b]),
            .o_dirty(bank_dirty[b]), .o_reprio(bank_reprio[b])
        );
    end

    page_collect #(.PAGE_W(PAGE_W), .OFFS_W(OFFS_W), .BANK_W(BANK_W)) u_page_collect (
        .clk,
        .i_vaddr(vaddr), .i_attr_page(attr_page), .i_no_paging(no_paging),
        .i_bank_map(bank_map), .i_bank_used(bank_used),
        .i_bank_dirty(bank_dirty), .i_bank_reprio(bank_reprio),
        .o_map_entry(map_entry), .o_xlat_page(xlat_page), .o_physad(physad),
        .o_used(used), .o_dirty(dirty), .o_reprio(reprio)
    );

endmodule

//--- tb/tb_mmu_model.svh
// MMU reference model
`ifndef TB_MMU_MODEL_SVH
`define TB_MMU_MODEL_SVH

localparam int PAGES = 2 ** mmu_pkg::PAGE_W;    // Pages in the map

mmu_pkg::page_t  map_q     [PAGES];             // Written map entries
bit              map_ok    [PAGES];
bit              used_q    [PAGES];
bit              used_ok   [PAGES];
bit              dirty_q   [PAGES];
bit              dirty_ok  [PAGES];
bit              reprio_q  [PAGES];
bit              reprio_ok [PAGES];
logic            no_paging_q;
mmu_pkg::vaddr_t vaddr_q;
mmu_pkg::page_t  physpg_q;

function automatic mmu_pkg::page_t vpage_of(input mmu_pkg::vaddr_t va);
    return va[mmu_pkg::OFFS_W +: mmu_pkg::PAGE_W];  // Page field of an address
endfunction

// Only predictable with bypass on or a written entry
function automatic bit xlat_known();
    return no_paging_q || map_ok[vpage_of(vaddr_q)];
endfunction

function automatic mmu_pkg::page_t xlat_expect();
    return no_paging_q ? vpage_of(vaddr_q) : map_q[vpage_of(vaddr_q)];
endfunction

function automatic mmu_pkg::paddr_t physad_expect();
    return {xlat_expect(), vaddr_q[mmu_pkg::OFFS_W-1:0]}; // Offset unchanged
endfunction

task automatic clear_model();
    for (int p = 0; p < PAGES; p++) begin
        map_ok[p]    = 1'b0;
        used_ok[p]   = 1'b0;
        dirty_ok[p]  = 1'b0;
        reprio_ok[p] = 1'b0;
    end
    no_paging_q = 1'b0;
    vaddr_q     = '0;
    physpg_q    = '0;
endtask

// Effect of a successful register write
task automatic apply_write(input mmu_pkg::apb_addr_t a, input mmu_pkg::apb_data_t d);
    mmu_pkg::page_t vp;
    vp = vpage_of(vaddr_q);
    case (a)
        mmu_pkg::REG_CTRL: begin
            no_paging_q = d[0];
            if (d[1]) begin                     // Fill, start page to last
                for (int p = int'(physpg_q); p < PAGES; p++) begin
                    reprio_q[p]  = 1'b1;
                    reprio_ok[p] = 1'b1;
                end
            end
        end
        mmu_pkg::REG_VADDR:  vaddr_q = mmu_pkg::vaddr_t'(d);
        mmu_pkg::REG_MAPENT: begin
            map_q[vp]  = mmu_pkg::page_t'(d);
            map_ok[vp] = 1'b1;
        end
        mmu_pkg::REG_PHYSPG: physpg_q = mmu_pkg::page_t'(d);
        mmu_pkg::REG_ACCESS: begin
            used_q[physpg_q]   = d[1];
            used_ok[physpg_q]  = 1'b1;
            dirty_q[physpg_q]  = d[2];
            dirty_ok[physpg_q] = 1'b1;
        end
        mmu_pkg::REG_REPRIO: begin
            reprio_q[physpg_q]  = d[0];
            reprio_ok[physpg_q] = 1'b1;
        end
        mmu_pkg::REG_TRANSLATE: begin
            physpg_q          = xlat_expect();  // Dirty stays as it was
            used_q[physpg_q]  = 1'b1;
            used_ok[physpg_q] = 1'b1;
        end
        default: ;
    endcase
endtask

`endif

//--- tb/tb_mmu.sv
// MMU testbench
`timescale 1ns/1ps

module tb_mmu;

    localparam int N_STEPS = 200;               // Random test steps
    localparam int XFERS   = 16;                // Upper bound of transfers in one step
    localparam int N_FILLS = N_STEPS / 50;      // One fill every 50 steps
    localparam int LIMIT   = N_STEPS * XFERS * 8 + N_FILLS * (1024 + 40) + 16;

    logic               clk = 1'b0;
    logic               reset;
    logic               psel;
    logic               penable;
    logic               pwrite;
    mmu_pkg::apb_addr_t paddr;
    mmu_pkg::apb_data_t pwdata;
    mmu_pkg::apb_data_t prdata;
    logic               pready;
    logic               pslverr;
    logic [31:0]        rng_state = 32'ha0d0_1a06;
    int                 cycles = 0;
    mmu_pkg::apb_data_t rd;                     // Data of last transfer
    logic               err;                    // Slave error of last transfer

    `include "tb_mmu_model.svh"

    always #5 clk = ~clk;                       // 10 ns period

    mmu_top u_mmu_top (
        .clk, .reset,
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata),
        .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
    );

    // ----------------------------------------------------------
    // Failure handling and checks
    // ----------------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
            stop_run($sformatf("ERR %s expected 0x%08h actual 0x%08h", name, exp, act));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT)
            stop_run($sformatf("Timeout, run still going after %0d cycles", cycles));
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);                      // Xorshift32
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // ----------------------------------------------------------
    // APB master called and returning at a falling edge
    // ----------------------------------------------------------
    task automatic apb_xfer(input logic wr, input mmu_pkg::apb_addr_t a,
                            input mmu_pkg::apb_data_t d);
        psel    = 1'b1;                         // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(negedge clk);
        if (pready)
            stop_run($sformatf("pready high in first access cycle, offset 0x%02h", a));
        penable = 1'b1;
        @(negedge clk);
        if (!pready)
            stop_run($sformatf("pready missing in second access cycle, offset 0x%02h", a));
        rd  = prdata;
        err = pslverr;
        @(negedge clk);                         // Completing edge passed
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input mmu_pkg::apb_addr_t a, input mmu_pkg::apb_data_t d,
                             input string name);
        apb_xfer(1'b1, a, d);
        check({name, " slverr"}, 32'd0, 32'(err));
        apply_write(a, d);
    endtask

    task automatic read_expect(input mmu_pkg::apb_addr_t a, input mmu_pkg::apb_data_t exp,
                               input mmu_pkg::apb_data_t mask, input string name);
        apb_xfer(1'b0, a, '0);
        check({name, " slverr"}, 32'd0, 32'(err));
        check(name, exp & mask, rd & mask);     // Unwritten bits masked off
    endtask

    // Used, dirty and reprioritize bits of the PHYSPG page
    task automatic check_attr(input string name);
        mmu_pkg::apb_data_t mask;
        mmu_pkg::apb_data_t exp;
        mask = 32'hffff_fff9 | (used_ok[physpg_q] ? 32'h2 : 32'h0)
                             | (dirty_ok[physpg_q] ? 32'h4 : 32'h0);
        exp  = {29'd0, dirty_q[physpg_q], used_q[physpg_q], 1'b0};
        read_expect(mmu_pkg::REG_ACCESS, exp, mask, {name, " access"});
        mask = reprio_ok[physpg_q] ? 32'hffff_ffff : 32'hffff_fffe;
        read_expect(mmu_pkg::REG_REPRIO, {31'd0, reprio_q[physpg_q]}, mask, {name, " reprio"});
    endtask

    // ----------------------------------------------------------
    // Test steps
    // ----------------------------------------------------------
    task automatic map_test();
        write_reg(mmu_pkg::REG_VADDR, next_rand(), "map vaddr");
        write_reg(mmu_pkg::REG_MAPENT, next_rand(), "map write");
        read_expect(mmu_pkg::REG_MAPENT, 32'(map_q[vpage_of(vaddr_q)]), '1, "map readback");
        read_expect(mmu_pkg::REG_PHYSAD, 32'(physad_expect()), '1, "map physad");
    endtask

    task automatic bypass_test();
        write_reg(mmu_pkg::REG_VADDR, next_rand(), "bypass vaddr");
        write_reg(mmu_pkg::REG_CTRL, 32'h1, "bypass on");
        read_expect(mmu_pkg::REG_CTRL, 32'h1, '1, "bypass ctrl");
        read_expect(mmu_pkg::REG_PHYSAD, 32'(vaddr_q), '1, "bypass physad");
        write_reg(mmu_pkg::REG_CTRL, 32'h0, "bypass off");
        if (xlat_known())
            read_expect(mmu_pkg::REG_PHYSAD, 32'(physad_expect()), '1, "paged physad");
    endtask

    task automatic attr_test();
        mmu_pkg::page_t p;
        mmu_pkg::page_t q;
        p = mmu_pkg::page_t'(next_rand());
        q = p ^ mmu_pkg::page_t'(next_rand() % (2 ** mmu_pkg::BANK_W - 1) + 1)
              ^ (mmu_pkg::page_t'(next_rand()) << mmu_pkg::BANK_W); // Other bank
        write_reg(mmu_pkg::REG_PHYSPG, 32'(p), "attr page p");
        write_reg(mmu_pkg::REG_ACCESS, next_rand(), "attr access p");
        write_reg(mmu_pkg::REG_REPRIO, next_rand(), "attr reprio p");
        write_reg(mmu_pkg::REG_PHYSPG, 32'(q), "attr page q");
        write_reg(mmu_pkg::REG_ACCESS, next_rand(), "attr access q");
        write_reg(mmu_pkg::REG_REPRIO, next_rand(), "attr reprio q");
        write_reg(mmu_pkg::REG_PHYSPG, 32'(p), "attr back to p");
        check_attr("attr p");
        write_reg(mmu_pkg::REG_PHYSPG, 32'(q), "attr back to q");
        check_attr("attr q");
    endtask

    task automatic xlat_test();
        mmu_pkg::page_t tp;
        write_reg(mmu_pkg::REG_VADDR, next_rand(), "xlat vaddr");
        if (!xlat_known())
            write_reg(mmu_pkg::REG_MAPENT, next_rand(), "xlat map");
        tp = xlat_expect();
        write_reg(mmu_pkg::REG_PHYSPG, 32'(tp), "xlat target");
        write_reg(mmu_pkg::REG_ACCESS, next_rand() & 32'h4, "xlat clear used"); // Dirty random
        write_reg(mmu_pkg::REG_PHYSPG, next_rand(), "xlat scramble");
        write_reg(mmu_pkg::REG_TRANSLATE, next_rand(), "translate");
        read_expect(mmu_pkg::REG_PHYSPG, 32'(tp), '1, "xlat physpg");
        check_attr("xlat");
    endtask

    task automatic bad_offset_test();
        mmu_pkg::apb_addr_t a;
        a = mmu_pkg::apb_addr_t'(next_rand());
        if (a <= 8'h1C && a[1:0] == 2'b00)
            a = a | 8'h80;                      // Move off the register map
        apb_xfer(1'b0, a, '0);
        check("bad read slverr", 32'd1, 32'(err));
        check("bad read data", 32'd0, rd);
        apb_xfer(1'b1, a, next_rand());
        check("bad write slverr", 32'd1, 32'(err));
        read_expect(mmu_pkg::REG_CTRL, {31'd0, no_paging_q}, '1, "bad ctrl");
        read_expect(mmu_pkg::REG_VADDR, 32'(vaddr_q), '1, "bad vaddr");
        read_expect(mmu_pkg::REG_PHYSPG, 32'(physpg_q), '1, "bad physpg");
    endtask

    task automatic fill_test();
        mmu_pkg::page_t start;
        int             polls;
        start = mmu_pkg::page_t'(next_rand() % (PAGES - 32)); // Room for busy checks
        if (start != 0) begin                   // Known zero just below the fill
            write_reg(mmu_pkg::REG_PHYSPG, 32'(start - 1'b1), "fill below page");
            write_reg(mmu_pkg::REG_REPRIO, 32'h0, "fill below clear");
        end
        write_reg(mmu_pkg::REG_PHYSPG, 32'(start), "fill page");
        write_reg(mmu_pkg::REG_ACCESS, next_rand(), "fill access");
        write_reg(mmu_pkg::REG_CTRL, 32'h2, "fill start");
        read_expect(mmu_pkg::REG_CTRL, 32'h2, '1, "fill busy");
        apb_xfer(1'b1, mmu_pkg::REG_ACCESS, next_rand());
        check("busy access slverr", 32'd1, 32'(err));
        apb_xfer(1'b0, mmu_pkg::REG_REPRIO, '0);
        check("busy reprio slverr", 32'd1, 32'(err));
        check("busy reprio data", 32'd0, rd);
        apb_xfer(1'b1, mmu_pkg::REG_TRANSLATE, next_rand());
        check("busy translate slverr", 32'd1, 32'(err));
        polls = 0;
        do begin                                // Wait for busy to fall
            apb_xfer(1'b0, mmu_pkg::REG_CTRL, '0);
            polls++;
            if (polls > PAGES)
                stop_run("Fill busy never cleared");
        end while (rd[1]);
        read_expect(mmu_pkg::REG_PHYSPG, 32'(start), '1, "fill physpg kept");
        check_attr("fill start page");
        if (start != 0) begin
            write_reg(mmu_pkg::REG_PHYSPG, 32'(start - 1'b1), "fill below");
            check_attr("fill below start");
            write_reg(mmu_pkg::REG_PHYSPG, next_rand() % start, "fill low");
            check_attr("fill low page");
        end
        write_reg(mmu_pkg::REG_PHYSPG, 32'(PAGES - 1), "fill last");
        check_attr("fill last page");
        write_reg(mmu_pkg::REG_PHYSPG, start + next_rand() % (PAGES - start), "fill mid");
        check_attr("fill mid page");
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        clear_model();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        check("reset pready", 32'd0, 32'(pready));
        check("reset pslverr", 32'd0, 32'(pslverr));
        read_expect(mmu_pkg::REG_CTRL, 32'd0, '1, "reset ctrl");
        read_expect(mmu_pkg::REG_VADDR, 32'd0, '1, "reset vaddr");
        read_expect(mmu_pkg::REG_PHYSPG, 32'd0, '1, "reset physpg");
        for (int step = 0; step < N_STEPS; step++) begin
            if (step % 50 == 25) begin
                fill_test();
            end else begin
                case (next_rand() % 5)
                    0:       map_test();
                    1:       bypass_test();
                    2:       attr_test();
                    3:       xlat_test();
                    default: bad_offset_test();
                endcase
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- build.f
+incdir+tb
design/mmu_pkg.sv
design/mmu_apb_regs.sv
design/page_dispatch.sv
design/page_bank.sv
design/page_collect.sv
design/mmu_top.sv
tb/tb_mmu.sv

//--- run.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -sv -Wno-fatal -f build.f --top-module tb_mmu -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mmu > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
